// File: sources.f
verilog/eeprom_pkg.sv
verilog/eeprom_cmd_latch.sv
verilog/eeprom_seq.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_ctrl.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

// File: bench/tb_eeprom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eeprom_ctrl import eeprom_pkg::*; ();

  localparam int TIMEOUT = 2000;

  logic     clk;
  logic     arst_n;
  logic     wr;
  logic     rd;
  ee_addr_t addr;
  byte_t    wr_data;
  byte_t    rd_data;
  logic     ack;
  logic     busy;
  logic     scl;
  wire      sda;
  int       errors;
  int       checks;
  int       seed;

  pullup (sda);

  eeprom_ctrl #(.QUARTER_CYCLES(2)) i_dut (.*);

  eeprom_model i_model (.scl(scl), .sda(sda));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_data(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic strobe(input logic w, input logic r, input ee_addr_t a, input byte_t d);
    @(posedge clk);
    wr      <= w;
    rd      <= r;
    addr    <= a;
    wr_data <= d;
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
  endtask

  // busy holds through the ack cycle and drops right after
  task automatic wait_ack(output byte_t data);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    data = '0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      seen = ack;
      data = rd_data;
      n++;
    end
    if (!seen) begin
      errors++;
      $display("timeout, no ack within %0d cycles", TIMEOUT);
    end else begin
      @(negedge clk);
      check_flag("busy", busy, 1'b0);
      check_flag("ack", ack, 1'b0);
    end
  endtask

  task automatic write_byte(input ee_addr_t a, input byte_t d);
    byte_t unused;
    strobe(1'b1, 1'b0, a, d);
    wait_ack(unused);
  endtask

  task automatic read_check(input ee_addr_t a, input byte_t exp);
    byte_t got;
    strobe(1'b0, 1'b1, a, '0);
    wait_ack(got);
    check_data("rd_data", got, exp);
  endtask

  task automatic reset_values();
    int e;
    e = errors;
    @(negedge clk);
    check_flag("ack", ack, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_flag("scl", scl, 1'b1);
    check_flag("sda", sda, 1'b1);
    check_data("rd_data", rd_data, '0);
    report_test("reset state", e);
  endtask

  task automatic write_read_back();
    int e;
    e = errors;
    write_byte(11'h123, 8'h5a);
    read_check(11'h123, 8'h5a);
    report_test("write then read", e);
  endtask

  // same low byte, only the block select differs
  task automatic block_select();
    int e;
    e = errors;
    write_byte(11'h005, 8'h11);
    write_byte(11'h105, 8'h22);
    write_byte(11'h705, 8'h77);
    read_check(11'h005, 8'h11);
    read_check(11'h105, 8'h22);
    read_check(11'h705, 8'h77);
    report_test("upper address bits", e);
  endtask

  task automatic busy_drop();
    int    e;
    byte_t unused;
    e = errors;
    strobe(1'b1, 1'b0, 11'h2a0, 8'hc3);
    strobe(1'b1, 1'b0, 11'h2a0, 8'h3c);
    strobe(1'b0, 1'b1, 11'h2a1, 8'h00);
    wait_ack(unused);
    repeat (20) begin  // bus idle, no second ack
      @(negedge clk);
      check_flag("ack", ack, 1'b0);
      check_flag("busy", busy, 1'b0);
      check_flag("scl", scl, 1'b1);
      check_flag("sda", sda, 1'b1);
    end
    read_check(11'h2a0, 8'hc3);
    report_test("strobe while busy", e);
  endtask

  task automatic random_traffic();
    int       e;
    int       k;
    logic     dup;
    ee_addr_t addrs [8];
    byte_t    vals [8];
    e = errors;
    for (int i = 0; i < 8; i++) begin
      dup = 1'b1;
      while (dup) begin
        addrs[i] = ee_addr_t'($random(seed));
        dup      = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (addrs[j] == addrs[i]) dup = 1'b1;
        end
      end
      vals[i] = byte_t'($random(seed));
      write_byte(addrs[i], vals[i]);
    end
    for (int i = 0; i < 8; i++) begin
      k = (i * 5 + 3) % 8;  // shuffled order
      read_check(addrs[k], vals[k]);
    end
    report_test("random traffic", e);
  endtask

  task automatic dual_strobe();
    int    e;
    byte_t unused;
    e = errors;
    write_byte(11'h3ff, 8'h00);
    strobe(1'b1, 1'b1, 11'h3ff, 8'h96);
    wait_ack(unused);
    read_check(11'h3ff, 8'h96);
    report_test("both strobes", e);
  endtask

  initial begin
    seed    = 99;
    errors  = 0;
    checks  = 0;
    arst_n  = 1'b0;
    wr      = 1'b0;
    rd      = 1'b0;
    addr    = '0;
    wr_data = '0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    reset_values();
    write_read_back();
    block_select();
    busy_drop();
    random_traffic();
    dual_strobe();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_model import eeprom_pkg::*; (
  input wire scl,
  inout wire sda
);

  byte_t      mem [0:2047];
  ee_addr_t   ptr;
  byte_t      sr;
  logic       sda_drive;
  logic [3:0] bitcnt;
  logic [1:0] phase;  // 0 control, 1 word address, 2 data
  logic       sel;
  logic       reading;

  assign sda = sda_drive ? 1'b0 : 1'bz;

  initial begin
    for (int i = 0; i < 2048; i++) begin
      mem[i] = byte_t'(i ^ (i >> 3));  // block bits fold into the fill
    end
    ptr       = '0;
    sr        = '0;
    sda_drive = 1'b0;
    bitcnt    = '0;
    phase     = '0;
    sel       = 1'b0;
    reading   = 1'b0;
  end

  // start or repeated start
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      bitcnt  = '0;
      phase   = '0;
      sel     = 1'b0;
      reading = 1'b0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin
      bitcnt  = '0;
      sel     = 1'b0;
      reading = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (reading && bitcnt == 4'd8 && sda === 1'b1) begin
      reading = 1'b0;  // no-ack from master ends the read
    end
    if (!reading && bitcnt < 4'd8) begin
      sr = {sr[6:0], sda === 1'b1};
    end
    bitcnt = bitcnt + 4'd1;
  end

  always @(negedge scl) begin
    if (bitcnt == 4'd8) begin
      sda_drive = 1'b0;
      if (!reading) take_byte();
    end else if (bitcnt == 4'd9) begin
      bitcnt    = '0;
      sda_drive = reading && !mem[ptr][7];
    end else if (reading) begin
      sda_drive = !mem[ptr][7 - bitcnt];
    end
  end

  task automatic take_byte();
    if (phase == 2'd0) begin
      sel = (sr[7:4] == DEV_TYPE);
      if (sel) ptr[10:8] = sr[3:1];
      reading = sel && sr[0];
      phase   = 2'd1;
    end else if (phase == 2'd1) begin
      ptr[7:0] = sr;
      phase    = 2'd2;
    end else begin
      mem[ptr] = sr;
      ptr      = ptr + 1'b1;
    end
    sda_drive = sel;  // ack
  endtask

endmodule

`default_nettype wire

// File: verilog/eeprom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_ctrl import eeprom_pkg::*; #(
  parameter int QUARTER_CYCLES = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     wr,
  input  logic     rd,
  input  ee_addr_t addr,
  input  byte_t    wr_data,
  output byte_t    rd_data,
  output logic     ack,
  output logic     busy,
  output logic     scl,
  inout  wire      sda
);

  cmd_t  cmd;
  logic  cmd_pending;
  logic  done;
  logic  sym_go;
  sym_e  sym;
  byte_t tx_byte;
  logic  sym_done;
  byte_t rx_byte;
  logic  sda_low;
  logic  sda_in;

  eeprom_cmd_latch i_latch (
    .clk         (clk),
    .arst_n      (arst_n),
    .wr          (wr),
    .rd          (rd),
    .addr        (addr),
    .wr_data     (wr_data),
    .done        (done),
    .cmd         (cmd),
    .cmd_pending (cmd_pending)
  );

  eeprom_seq i_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd         (cmd),
    .cmd_pending (cmd_pending),
    .sym_done    (sym_done),
    .rx_byte     (rx_byte),
    .sym_go      (sym_go),
    .sym         (sym),
    .tx_byte     (tx_byte),
    .done        (done),
    .rd_data     (rd_data)
  );

  i2c_bit_engine #(
    .QUARTER_CYCLES (QUARTER_CYCLES)
  ) i_engine (
    .clk      (clk),
    .arst_n   (arst_n),
    .sym_go   (sym_go),
    .sym      (sym),
    .tx_byte  (tx_byte),
    .sda_in   (sda_in),
    .scl      (scl),
    .sda_low  (sda_low),
    .sym_done (sym_done),
    .rx_byte  (rx_byte)
  );

  // open drain, pull-up is off chip
  assign sda    = sda_low ? 1'b0 : 1'bz;
  assign sda_in = sda;

  assign busy = cmd_pending;
  assign ack  = done;

endmodule

`default_nettype wire

// File: verilog/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine import eeprom_pkg::*; #(
  parameter int QUARTER_CYCLES = 4
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  sym_go,
  input  sym_e  sym,
  input  byte_t tx_byte,
  input  logic  sda_in,
  output logic  scl,
  output logic  sda_low,
  output logic  sym_done,
  output byte_t rx_byte
);

  localparam int DIV_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(QUARTER_CYCLES - 1);

  logic             active;
  logic             active_nxt;
  sym_e             sym_r;
  sym_e             sym_nxt;
  logic [DIV_W-1:0] div;
  logic [DIV_W-1:0] div_nxt;
  logic [1:0]       qcnt;      // quarter within the bit
  logic [1:0]       q_nxt;
  logic [3:0]       bitcnt;    // 0..8 for bytes
  logic [3:0]       bit_nxt;
  byte_t            shift;
  byte_t            shift_nxt;
  logic             quarter_end;
  logic             last_bit;
  logic             scl_d;
  logic             sda_low_d;

  assign quarter_end = (div == DIV_LAST);
  assign last_bit    = (sym_r inside {SYM_START, SYM_STOP}) || (bitcnt == 4'd8);
  assign sym_done    = active && quarter_end && (qcnt == 2'd3) && last_bit;

  always_comb begin
    active_nxt = active;
    sym_nxt    = sym_r;
    div_nxt    = div;
    q_nxt      = qcnt;
    bit_nxt    = bitcnt;
    shift_nxt  = shift;
    if (!active) begin
      if (sym_go) begin
        active_nxt = 1'b1;
        sym_nxt    = sym;
        div_nxt    = '0;
        q_nxt      = '0;
        bit_nxt    = '0;
        shift_nxt  = tx_byte;
      end
    end else if (quarter_end) begin
      div_nxt = '0;
      q_nxt   = qcnt + 2'd1;
      if (qcnt == 2'd3) begin
        bit_nxt   = bitcnt + 4'd1;
        shift_nxt = {shift[6:0], 1'b0};  // msb first
        if (last_bit) active_nxt = 1'b0;
      end
    end else begin
      div_nxt = div + 1'b1;
    end
  end

  // line levels for the phase being entered, so pins come straight off flops
  always_comb begin
    scl_d     = scl;
    sda_low_d = sda_low;
    if (active_nxt) begin
      unique case (sym_nxt)
        SYM_START: begin
          scl_d     = (q_nxt == 2'd0) ? scl : (q_nxt != 2'd3);
          sda_low_d = (q_nxt >= 2'd2);
        end
        SYM_STOP: begin
          scl_d     = (q_nxt != 2'd0);
          sda_low_d = (q_nxt != 2'd3);
        end
        SYM_WRITE: begin
          scl_d     = (q_nxt == 2'd1) || (q_nxt == 2'd2);
          sda_low_d = (bit_nxt != 4'd8) && !shift_nxt[7];  // ninth bit left to slave
        end
        default: begin
          scl_d     = (q_nxt == 2'd1) || (q_nxt == 2'd2);
          sda_low_d = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active  <= 1'b0;
      div     <= '0;
      qcnt    <= '0;
      bitcnt  <= '0;
      scl     <= 1'b1;
      sda_low <= 1'b0;
    end else begin
      active  <= active_nxt;
      div     <= div_nxt;
      qcnt    <= q_nxt;
      bitcnt  <= bit_nxt;
      scl     <= scl_d;
      sda_low <= sda_low_d;
    end
  end

  always_ff @(posedge clk) begin
    sym_r <= sym_nxt;
    shift <= shift_nxt;
    // sample mid scl high, data bits only
    if (active && sym_r == SYM_READ && qcnt == 2'd2 && div == '0 && bitcnt < 4'd8) begin
      rx_byte <= {rx_byte[6:0], sda_in};
    end
  end

endmodule

`default_nettype wire

// File: verilog/eeprom_seq.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_seq import eeprom_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  cmd_t  cmd,
  input  logic  cmd_pending,
  input  logic  sym_done,
  input  byte_t rx_byte,
  output logic  sym_go,
  output sym_e  sym,
  output byte_t tx_byte,
  output logic  done,
  output byte_t rd_data
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_START,
    ST_CTRL,
    ST_ADDR,
    ST_DOUT,
    ST_RESTART,
    ST_CTRL_RD,
    ST_DIN,
    ST_STOP,
    ST_FINISH
  } state_e;

  state_e state;
  state_e state_nxt;
  byte_t  ctrl_wr;
  byte_t  ctrl_rd;

  // block select bits ride in the control byte
  assign ctrl_wr = {DEV_TYPE, cmd.addr[10:8], 1'b0};
  assign ctrl_rd = {DEV_TYPE, cmd.addr[10:8], 1'b1};

  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE:    if (cmd_pending) state_nxt = ST_START;
      ST_START:   if (sym_done) state_nxt = ST_CTRL;
      ST_CTRL:    if (sym_done) state_nxt = ST_ADDR;
      ST_ADDR: begin
        if (sym_done) begin
          state_nxt = (cmd.op == OP_READ) ? ST_RESTART : ST_DOUT;
        end
      end
      ST_DOUT:    if (sym_done) state_nxt = ST_STOP;
      ST_RESTART: if (sym_done) state_nxt = ST_CTRL_RD;
      ST_CTRL_RD: if (sym_done) state_nxt = ST_DIN;
      ST_DIN:     if (sym_done) state_nxt = ST_STOP;
      ST_STOP:    if (sym_done) state_nxt = ST_FINISH;
      ST_FINISH:  state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  // symbol and byte for the current state
  always_comb begin
    sym     = SYM_START;
    tx_byte = '0;
    unique case (state)
      ST_CTRL: begin
        sym     = SYM_WRITE;
        tx_byte = ctrl_wr;
      end
      ST_ADDR: begin
        sym     = SYM_WRITE;
        tx_byte = cmd.addr[7:0];
      end
      ST_DOUT: begin
        sym     = SYM_WRITE;
        tx_byte = cmd.data;
      end
      ST_CTRL_RD: begin
        sym     = SYM_WRITE;
        tx_byte = ctrl_rd;
      end
      ST_DIN:  sym = SYM_READ;
      ST_STOP: sym = SYM_STOP;
      default: sym = SYM_START;  // idle, start, restart, finish
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      sym_go  <= 1'b0;
      rd_data <= '0;
    end else begin
      state  <= state_nxt;
      // one go per entry into a symbol state
      sym_go <= (state_nxt != state) && !(state_nxt inside {ST_IDLE, ST_FINISH});
      if (state == ST_DIN && sym_done) begin
        rd_data <= rx_byte;
      end
    end
  end

  assign done = (state == ST_FINISH);

endmodule

`default_nettype wire

// File: verilog/eeprom_cmd_latch.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_cmd_latch import eeprom_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     wr,
  input  logic     rd,
  input  ee_addr_t addr,
  input  byte_t    wr_data,
  input  logic     done,
  output cmd_t     cmd,
  output logic     cmd_pending
);

  logic accept;

  // strobes while busy are simply dropped
  assign accept = !cmd_pending && (wr || rd);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_pending <= 1'b0;
    end else if (done) begin
      cmd_pending <= 1'b0;
    end else if (accept) begin
      cmd_pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.op   <= wr ? OP_WRITE : OP_READ;  // wr has priority
      cmd.addr <= addr;
      cmd.data <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

  // word address into the 2k x 8 array
  typedef logic [10:0] ee_addr_t;
  typedef logic [7:0]  byte_t;

  typedef enum logic {
    OP_WRITE,
    OP_READ
  } cmd_op_e;

  // one host request as held by the latch
  typedef struct packed {
    cmd_op_e  op;
    ee_addr_t addr;
    byte_t    data;
  } cmd_t;

  // bus action for the bit engine
  typedef enum logic [1:0] {
    SYM_START,
    SYM_STOP,
    SYM_WRITE,  // byte out, ninth bit released for the slave ack
    SYM_READ    // byte in, ninth bit released as no-ack
  } sym_e;

  localparam logic [3:0] DEV_TYPE = 4'b1010;

endpackage

`default_nettype wire
